// ==== rtl/epu_bus_pkg.sv ====
`default_nettype none

package epu_bus_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int len_w  = 8;

    // Address map, one buffer word per 4 bytes
    localparam logic [addr_w-1:0] buf_base   = 32'h5000_0000;
    localparam logic [addr_w-1:0] reg_weight = 32'h8000_0000;
    localparam logic [addr_w-1:0] reg_ctrl   = 32'h8000_0004;
    localparam logic [addr_w-1:0] reg_status = 32'h8000_0008;

    typedef enum logic [2:0] {
        IDLE    = 3'h0,
        WR      = 3'h1,
        RD_REQ  = 3'h2,
        RD_DATA = 3'h3,
        RESP    = 3'h4
    } slave_state_t;

endpackage

`default_nettype wire

// ==== rtl/epu_core_pkg.sv ====
`default_nettype none

package epu_core_pkg;

    localparam int buf_words = 256;
    // Input region starts at word 0
    localparam int out_base  = 128;

    typedef enum logic [1:0] {
        MODE_MUL  = 2'h0,
        MODE_RELU = 2'h1,
        MODE_SHR  = 2'h2,
        MODE_ADD  = 2'h3
    } conv_mode_t;

    typedef enum logic [1:0] {
        IDLE  = 2'h0,
        READ  = 2'h1,
        WAIT  = 2'h2,
        WRITE = 2'h3
    } engine_state_t;

endpackage

`default_nettype wire

// ==== rtl/sram_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface sram_if #(
    parameter int DEPTH = 256
);
    import epu_bus_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic              req;
    logic              we;
    logic [AW-1:0]     addr;
    logic [data_w-1:0] wdata;
    logic              gnt;
    // Valid one cycle after a granted read
    logic [data_w-1:0] rdata;

    modport requester (output req, we, addr, wdata, input gnt, rdata);
    modport memory    (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

// ==== rtl/epu_slave_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_slave_port #(
    parameter int DEPTH = epu_core_pkg::buf_words
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             awvalid_i,
    input  logic [epu_bus_pkg::addr_w-1:0]   awaddr_i,
    input  logic [epu_bus_pkg::len_w-1:0]    awlen_i,
    output logic                             awready_o,
    input  logic                             wvalid_i,
    input  logic [epu_bus_pkg::data_w-1:0]   wdata_i,
    input  logic                             wlast_i,
    output logic                             wready_o,
    output logic                             bvalid_o,
    input  logic                             bready_i,
    input  logic                             arvalid_i,
    input  logic [epu_bus_pkg::addr_w-1:0]   araddr_i,
    input  logic [epu_bus_pkg::len_w-1:0]    arlen_i,
    output logic                             arready_o,
    output logic                             rvalid_o,
    output logic [epu_bus_pkg::data_w-1:0]   rdata_o,
    output logic                             rlast_o,
    input  logic                             rready_i,
    sram_if.requester                        mem_o,
    output logic                             start_o,
    output epu_core_pkg::conv_mode_t         mode_o,
    output logic [7:0]                       count_o,
    output logic [epu_bus_pkg::data_w-1:0]   weight_o,
    input  logic                             finish_i,
    input  logic                             busy_i,
    output logic                             int_o
);
    import epu_bus_pkg::*;

    localparam int AW = $clog2(DEPTH);

    slave_state_t      state_r;
    logic              armed_r;
    logic [addr_w-1:0] addr_r;
    logic [len_w-1:0]  len_r;
    logic [len_w-1:0]  beat_r;
    logic [data_w-1:0] reg_rdata_r;
    logic              done_r;
    logic              is_buf;
    logic              aw_hs;
    logic              ar_hs;
    logic              w_hs;
    logic              r_hs;
    logic              wr_end;

    // Buffer window spans DEPTH words from buf_base
    assign is_buf = (addr_r >= buf_base) && (addr_r < buf_base + addr_w'(DEPTH * 4));

    // Readies stay low until the first cycle out of reset
    assign awready_o = armed_r && (state_r == IDLE);
    assign arready_o = armed_r && (state_r == IDLE) && !awvalid_i;
    assign aw_hs     = awvalid_i && awready_o;
    assign ar_hs     = arvalid_i && arready_o;

    assign wready_o = (state_r == WR) && (is_buf ? mem_o.gnt : 1'b1);
    assign w_hs     = wvalid_i && wready_o;
    assign wr_end   = w_hs && (wlast_i || beat_r == len_r);
    assign bvalid_o = state_r == RESP;

    assign rvalid_o = state_r == RD_DATA;
    assign rlast_o  = rvalid_o && (beat_r == len_r);
    assign r_hs     = rvalid_o && rready_i;
    assign rdata_o  = is_buf ? mem_o.rdata : reg_rdata_r;
    assign int_o    = done_r;

    // Word-indexed buffer requests
    assign mem_o.req   = is_buf && ((state_r == WR && wvalid_i) || state_r == RD_REQ);
    assign mem_o.we    = state_r == WR;
    assign mem_o.addr  = addr_r[AW+1:2];
    assign mem_o.wdata = wdata_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r <= IDLE;
            armed_r <= 1'b0;
            addr_r  <= '0;
            len_r   <= '0;
            beat_r  <= '0;
        end else begin
            armed_r <= 1'b1;
            case (state_r)
                IDLE: begin
                    if (aw_hs) begin
                        addr_r  <= awaddr_i;
                        len_r   <= awlen_i;
                        beat_r  <= '0;
                        state_r <= WR;
                    end else if (ar_hs) begin
                        addr_r  <= araddr_i;
                        len_r   <= arlen_i;
                        beat_r  <= '0;
                        state_r <= RD_REQ;
                    end
                end
                WR: begin
                    if (w_hs) begin
                        addr_r <= addr_r + addr_w'(4);
                        beat_r <= beat_r + len_w'(1);
                        if (wr_end) begin
                            state_r <= RESP;
                        end
                    end
                end
                RD_REQ: begin
                    // Register beats need no grant
                    if (!is_buf || mem_o.gnt) begin
                        state_r <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_hs) begin
                        if (rlast_o) begin
                            state_r <= IDLE;
                        end else begin
                            addr_r  <= addr_r + addr_w'(4);
                            beat_r  <= beat_r + len_w'(1);
                            state_r <= RD_REQ;
                        end
                    end
                end
                RESP: begin
                    if (bready_i) begin
                        state_r <= IDLE;
                    end
                end
                default: state_r <= IDLE;
            endcase
        end
    end

    // Register read data, sampled while the beat starts
    always_ff @(posedge clk) begin
        if (state_r == RD_REQ) begin
            case (addr_r)
                reg_weight: reg_rdata_r <= weight_o;
                reg_ctrl:   reg_rdata_r <= data_w'({count_o, 5'h0, mode_o, 1'b0});
                reg_status: reg_rdata_r <= data_w'({busy_i, done_r});
                default:    reg_rdata_r <= '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weight_o <= '0;
            mode_o   <= epu_core_pkg::MODE_MUL;
            count_o  <= '0;
            start_o  <= 1'b0;
            done_r   <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (w_hs && addr_r == reg_weight) begin
                weight_o <= wdata_i;
            end
            if (w_hs && addr_r == reg_ctrl) begin
                mode_o  <= epu_core_pkg::conv_mode_t'(wdata_i[2:1]);
                count_o <= wdata_i[15:8];
                start_o <= wdata_i[0] && (wdata_i[15:8] != 8'h0);
                done_r  <= 1'b0;
            end
            // Engine finish wins over a clearing write
            if (finish_i) begin
                done_r <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/buffer_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module buffer_arbiter (
    input  logic      clk,
    input  logic      rst,
    sram_if.memory    eng_i,
    sram_if.memory    host_i,
    sram_if.requester mem_o
);
    import epu_bus_pkg::*;

    logic              eng_rd_r;
    logic              host_rd_r;
    logic [data_w-1:0] eng_hold_r;
    logic [data_w-1:0] host_hold_r;

    // Engine has fixed priority
    assign mem_o.req   = eng_i.req || host_i.req;
    assign mem_o.we    = eng_i.req ? eng_i.we    : host_i.we;
    assign mem_o.addr  = eng_i.req ? eng_i.addr  : host_i.addr;
    assign mem_o.wdata = eng_i.req ? eng_i.wdata : host_i.wdata;

    assign eng_i.gnt  = eng_i.req && mem_o.gnt;
    assign host_i.gnt = host_i.req && !eng_i.req && mem_o.gnt;

    // Owner of the read in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eng_rd_r  <= 1'b0;
            host_rd_r <= 1'b0;
        end else begin
            eng_rd_r  <= eng_i.gnt && !eng_i.we;
            host_rd_r <= host_i.gnt && !host_i.we;
        end
    end

    // Each side keeps its last result while the other one reads
    always_ff @(posedge clk) begin
        if (eng_rd_r) begin
            eng_hold_r <= mem_o.rdata;
        end
        if (host_rd_r) begin
            host_hold_r <= mem_o.rdata;
        end
    end

    assign eng_i.rdata  = eng_rd_r  ? mem_o.rdata : eng_hold_r;
    assign host_i.rdata = host_rd_r ? mem_o.rdata : host_hold_r;

endmodule

`default_nettype wire

// ==== rtl/buffer_sram.sv ====
`timescale 1ns/1ns
`default_nettype none

module buffer_sram #(
    parameter int DEPTH = epu_core_pkg::buf_words
) (
    input  logic   clk,
    sram_if.memory mem_i
);
    import epu_bus_pkg::*;

    logic [data_w-1:0] mem [DEPTH];

    // Single port, never busy
    assign mem_i.gnt = mem_i.req;

    always_ff @(posedge clk) begin
        if (mem_i.req) begin
            if (mem_i.we) begin
                mem[mem_i.addr] <= mem_i.wdata;
            end else begin
                // Data appears in the next cycle
                mem_i.rdata <= mem[mem_i.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/conv_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module conv_engine #(
    parameter int DEPTH    = epu_core_pkg::buf_words,
    parameter int OUT_BASE = epu_core_pkg::out_base
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start_i,
    input  epu_core_pkg::conv_mode_t       mode_i,
    input  logic [7:0]                     count_i,
    input  logic [epu_bus_pkg::data_w-1:0] weight_i,
    sram_if.requester                      mem_o,
    output logic                           busy_o,
    output logic                           finish_o
);
    import epu_core_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam int DW = $bits(weight_i);

    engine_state_t state_r;
    conv_mode_t    mode_r;
    logic [7:0]    count_r;
    logic [7:0]    idx_r;
    logic [DW-1:0] weight_r;
    logic [DW-1:0] result_r;
    logic [DW-1:0] product;
    logic [DW-1:0] op_result;

    // Low word of the product
    assign product = mem_o.rdata * weight_r;

    always_comb begin
        case (mode_r)
            MODE_MUL:  op_result = product;
            MODE_RELU: op_result = product[DW-1] ? '0 : product;
            MODE_SHR:  op_result = $signed(product) >>> 8;
            default:   op_result = mem_o.rdata + weight_r;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r  <= IDLE;
            mode_r   <= MODE_MUL;
            count_r  <= '0;
            idx_r    <= '0;
            finish_o <= 1'b0;
        end else begin
            finish_o <= 1'b0;
            case (state_r)
                IDLE: begin
                    if (start_i) begin
                        mode_r  <= mode_i;
                        count_r <= count_i;
                        idx_r   <= '0;
                        state_r <= READ;
                    end
                end
                READ: begin
                    if (mem_o.gnt) begin
                        state_r <= WAIT;
                    end
                end
                WAIT: state_r <= WRITE;
                WRITE: begin
                    if (mem_o.gnt) begin
                        if (idx_r == count_r - 8'd1) begin
                            state_r  <= IDLE;
                            finish_o <= 1'b1;
                        end else begin
                            idx_r   <= idx_r + 8'd1;
                            state_r <= READ;
                        end
                    end
                end
                default: state_r <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_r == IDLE && start_i) begin
            weight_r <= weight_i;
        end
        if (state_r == WAIT) begin
            result_r <= op_result;
        end
    end

    assign mem_o.req   = (state_r == READ) || (state_r == WRITE);
    assign mem_o.we    = state_r == WRITE;
    // Results land in the output region at the same offset
    assign mem_o.addr  = (state_r == WRITE) ? AW'(OUT_BASE) + AW'(idx_r) : AW'(idx_r);
    assign mem_o.wdata = result_r;
    assign busy_o      = state_r != IDLE;

endmodule

`default_nettype wire

// ==== rtl/epu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_top #(
    parameter int DEPTH    = epu_core_pkg::buf_words,
    parameter int OUT_BASE = epu_core_pkg::out_base
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           awvalid_i,
    input  logic [epu_bus_pkg::addr_w-1:0] awaddr_i,
    input  logic [epu_bus_pkg::len_w-1:0]  awlen_i,
    output logic                           awready_o,
    input  logic                           wvalid_i,
    input  logic [epu_bus_pkg::data_w-1:0] wdata_i,
    input  logic                           wlast_i,
    output logic                           wready_o,
    output logic                           bvalid_o,
    input  logic                           bready_i,
    input  logic                           arvalid_i,
    input  logic [epu_bus_pkg::addr_w-1:0] araddr_i,
    input  logic [epu_bus_pkg::len_w-1:0]  arlen_i,
    output logic                           arready_o,
    output logic                           rvalid_o,
    output logic [epu_bus_pkg::data_w-1:0] rdata_o,
    output logic                           rlast_o,
    input  logic                           rready_i,
    output logic                           int_o
);
    import epu_bus_pkg::*;
    import epu_core_pkg::*;

    logic              start;
    conv_mode_t        mode;
    logic [7:0]        count;
    logic [data_w-1:0] weight;
    logic              finish;
    logic              busy;

    sram_if #(.DEPTH(DEPTH)) host_bus ();
    sram_if #(.DEPTH(DEPTH)) eng_bus ();
    sram_if #(.DEPTH(DEPTH)) mem_bus ();

    epu_slave_port #(
        .DEPTH (DEPTH)
    ) u_slave (
        .clk       (clk),
        .rst       (rst),
        .awvalid_i (awvalid_i),
        .awaddr_i  (awaddr_i),
        .awlen_i   (awlen_i),
        .awready_o (awready_o),
        .wvalid_i  (wvalid_i),
        .wdata_i   (wdata_i),
        .wlast_i   (wlast_i),
        .wready_o  (wready_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .arvalid_i (arvalid_i),
        .araddr_i  (araddr_i),
        .arlen_i   (arlen_i),
        .arready_o (arready_o),
        .rvalid_o  (rvalid_o),
        .rdata_o   (rdata_o),
        .rlast_o   (rlast_o),
        .rready_i  (rready_i),
        .mem_o     (host_bus),
        .start_o   (start),
        .mode_o    (mode),
        .count_o   (count),
        .weight_o  (weight),
        .finish_i  (finish),
        .busy_i    (busy),
        .int_o     (int_o)
    );

    conv_engine #(
        .DEPTH    (DEPTH),
        .OUT_BASE (OUT_BASE)
    ) u_engine (
        .clk      (clk),
        .rst      (rst),
        .start_i  (start),
        .mode_i   (mode),
        .count_i  (count),
        .weight_i (weight),
        .mem_o    (eng_bus),
        .busy_o   (busy),
        .finish_o (finish)
    );

    buffer_arbiter u_arb (
        .clk    (clk),
        .rst    (rst),
        .eng_i  (eng_bus),
        .host_i (host_bus),
        .mem_o  (mem_bus)
    );

    buffer_sram #(
        .DEPTH (DEPTH)
    ) u_sram (
        .clk   (clk),
        .mem_i (mem_bus)
    );

endmodule

`default_nettype wire

// ==== verif/epu_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_checker (
    input logic clk,
    input logic rst,
    input logic rvalid_i,
    input logic rready_i
);
    int beats_seen   = 0;
    int beats_mark   = 0;
    int test_checks  = 0;
    int test_errors  = 0;
    int total_checks = 0;
    int total_errors = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    // Read beats accepted on the host port
    always @(posedge clk) begin
        if (!rst && rvalid_i && rready_i) begin
            beats_seen++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        test_errors++;
        $display("%s", what);
    endtask

    task automatic end_test(input string name, input int beats_req);
        int seen;
        seen = beats_seen - beats_mark;
        if (seen != beats_req) begin
            report_failure($sformatf("Read channel carried %0d beats but %0d were requested",
                                     seen, beats_req));
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d checks, %0d errors", tests_run, name,
                 (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
        beats_mark  = beats_seen;
    endtask

    task automatic report();
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, total_errors);
    endtask

    function automatic int error_count();
        return total_errors + test_errors;
    endfunction

endmodule

`default_nettype wire

// ==== verif/epu_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_assertions (
    input logic                           clk,
    input logic                           rst,
    input logic                           eng_req_i,
    input logic                           eng_gnt_i,
    input logic                           host_req_i,
    input logic                           host_gnt_i,
    input logic                           mem_req_i,
    input logic                           mem_gnt_i,
    input logic                           rvalid_i,
    input logic                           rready_i,
    input logic [epu_bus_pkg::data_w-1:0] rdata_i
);
    // Grants only answer a request
    eng_gnt_has_req: assert property (@(posedge clk) disable iff (rst) eng_gnt_i |-> eng_req_i)
        else $error("engine grant without request");
    host_gnt_has_req: assert property (@(posedge clk) disable iff (rst) host_gnt_i |-> host_req_i)
        else $error("host grant without request");
    mem_gnt_has_req: assert property (@(posedge clk) disable iff (rst) mem_gnt_i |-> mem_req_i)
        else $error("memory grant without request");

    one_owner: assert property (@(posedge clk) disable iff (rst) !(eng_gnt_i && host_gnt_i))
        else $error("engine and host granted together");

    // Read beat held under back-pressure
    rdata_held: assert property (@(posedge clk) disable iff (rst)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
        else $error("read beat changed before rready");

endmodule

bind buffer_arbiter epu_assertions arb_checks (
    .clk        (clk),
    .rst        (rst),
    .eng_req_i  (eng_i.req),
    .eng_gnt_i  (eng_i.gnt),
    .host_req_i (host_i.req),
    .host_gnt_i (host_i.gnt),
    .mem_req_i  (mem_o.req),
    .mem_gnt_i  (mem_o.gnt),
    .rvalid_i   (1'b0),
    .rready_i   (1'b0),
    .rdata_i    (32'h0)
);

bind epu_slave_port epu_assertions port_checks (
    .clk        (clk),
    .rst        (rst),
    .eng_req_i  (1'b0),
    .eng_gnt_i  (1'b0),
    .host_req_i (mem_o.req),
    .host_gnt_i (mem_o.gnt),
    .mem_req_i  (1'b0),
    .mem_gnt_i  (1'b0),
    .rvalid_i   (rvalid_o),
    .rready_i   (rready_i),
    .rdata_i    (rdata_o)
);

`default_nettype wire

// ==== verif/epu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_tb;
    import epu_bus_pkg::*;
    import epu_core_pkg::*;

    logic              clk;
    logic              rst;
    logic              awvalid;
    logic [addr_w-1:0] awaddr;
    logic [len_w-1:0]  awlen;
    logic              awready;
    logic              wvalid;
    logic [data_w-1:0] wdata;
    logic              wlast;
    logic              wready;
    logic              bvalid;
    logic              bready;
    logic              arvalid;
    logic [addr_w-1:0] araddr;
    logic [len_w-1:0]  arlen;
    logic              arready;
    logic              rvalid;
    logic [data_w-1:0] rdata;
    logic              rlast;
    logic              rready;
    logic              irq;

    logic [31:0]       lfsr_q;
    logic [data_w-1:0] model [buf_words];
    logic [data_w-1:0] wr_buf [buf_words];
    logic [data_w-1:0] rd_data [buf_words];
    int                gap_lvl      = 1;
    int                test_beats   = 0;
    int                limit_cycles = 0;

    always #2 clk = ~clk;

    epu_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .awvalid_i (awvalid),
        .awaddr_i  (awaddr),
        .awlen_i   (awlen),
        .awready_o (awready),
        .wvalid_i  (wvalid),
        .wdata_i   (wdata),
        .wlast_i   (wlast),
        .wready_o  (wready),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .arvalid_i (arvalid),
        .araddr_i  (araddr),
        .arlen_i   (arlen),
        .arready_o (arready),
        .rvalid_o  (rvalid),
        .rdata_o   (rdata),
        .rlast_o   (rlast),
        .rready_i  (rready),
        .int_o     (irq)
    );

    epu_checker chk0 (
        .clk      (clk),
        .rst      (rst),
        .rvalid_i (rvalid),
        .rready_i (rready)
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // High with probability set by gap_lvl
    function automatic logic coin();
        return int'(rand_bits(2)) >= gap_lvl;
    endfunction

    function automatic logic [data_w-1:0] expect_op(input int mode, input logic [data_w-1:0] x,
                                                     input logic [data_w-1:0] w);
        logic signed [data_w-1:0] p;
        p = x * w;
        case (conv_mode_t'(mode))
            MODE_MUL:  return p;
            MODE_RELU: return (p < 0) ? '0 : p;
            MODE_SHR:  return p >>> 8;
            default:   return x + w;
        endcase
    endfunction

    function automatic logic [data_w-1:0] ctrl_word(input int mode, input int count,
                                                     input logic start);
        return {16'h0, count[7:0], 5'h0, mode[1:0], start};
    endfunction

    task automatic write_burst(input logic [addr_w-1:0] addr, input int n);
        int i;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        awlen   = len_w'(n - 1);
        @(posedge clk);
        while (!awready) begin
            @(posedge clk);
        end
        @(negedge clk);
        awvalid = 1'b0;
        for (i = 0; i < n; i++) begin
            while (!coin()) begin
                @(negedge clk);
            end
            wvalid = 1'b1;
            wdata  = wr_buf[i];
            wlast  = (i == n - 1);
            @(posedge clk);
            while (!wready) begin
                @(posedge clk);
            end
            @(negedge clk);
            wvalid = 1'b0;
            wlast  = 1'b0;
        end
        bready = coin();
        @(posedge clk);
        while (!(bvalid && bready)) begin
            @(negedge clk);
            bready = coin();
            @(posedge clk);
        end
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_burst(input logic [addr_w-1:0] addr, input int n);
        int   i;
        logic last;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        arlen   = len_w'(n - 1);
        @(posedge clk);
        while (!arready) begin
            @(posedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        // Beats are taken until rlast so a short or long burst shows in the beat count
        i    = 0;
        last = 1'b0;
        while (!last) begin
            rready = coin();
            @(posedge clk);
            if (rvalid && rready) begin
                if (i < buf_words) begin
                    rd_data[i] = rdata;
                end
                last = rlast;
                i++;
            end
            @(negedge clk);
        end
        rready = 1'b0;
        test_beats += n;
    endtask

    task automatic write_word(input logic [addr_w-1:0] addr, input logic [data_w-1:0] value);
        wr_buf[0] = value;
        write_burst(addr, 1);
    endtask

    task automatic check_reg(input string name, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] exp);
        read_burst(addr, 1);
        chk0.check_value(name, rd_data[0], exp);
    endtask

    task automatic fill_input(input int start, input int n);
        int i;
        for (i = 0; i < n; i++) begin
            wr_buf[i] = rand_bits(32);
            model[start + i] = wr_buf[i];
        end
        write_burst(buf_base + addr_w'(4 * start), n);
    endtask

    // Burst read compared word by word with the model
    task automatic check_region(input int start, input int n);
        int i;
        read_burst(buf_base + addr_w'(4 * start), n);
        for (i = 0; i < n; i++) begin
            chk0.check_value("rdata", rd_data[i], model[start + i]);
        end
    endtask

    task automatic start_run(input int mode, input int count, input logic [data_w-1:0] weight);
        int i;
        for (i = 0; i < count; i++) begin
            model[out_base + i] = expect_op(mode, model[i], weight);
        end
        write_word(reg_weight, weight);
        write_word(reg_ctrl, ctrl_word(mode, count, 1'b1));
    endtask

    task automatic wait_irq(input int count);
        int cycles;
        cycles = 0;
        while (!irq && cycles < 8 * count + 100) begin
            @(posedge clk);
            cycles++;
        end
        chk0.check_value("int_o", 32'(irq), 32'h1);
    endtask

    task automatic finish_test(input string name);
        chk0.end_test(name, test_beats);
        test_beats = 0;
    endtask

    initial begin
        int                n1;
        int                s1;
        int                c2;
        int                cm [4];
        int                c4;
        int                s4;
        int                n4;
        int                s5;
        int                n5;
        int                m;
        int                words;
        logic [data_w-1:0] w;
        clk     = 1'b0;
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        awlen   = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wlast   = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arlen   = '0;
        rready  = 1'b0;
        lfsr_q  = 32'd21;

        // Lengths drawn up front so the watchdog knows the budget
        n1 = 1 + int'(rand_bits(6));
        s1 = int'(rand_bits(5));
        c2 = 16 + int'(rand_bits(4));
        words = out_base + 2 * n1 + 2 * c2;
        for (m = 0; m < 4; m++) begin
            cm[m] = 1 + int'(rand_bits(7));
            words += 2 * cm[m];
        end
        c4 = 32 + int'(rand_bits(5));
        s4 = int'(rand_bits(6));
        n4 = 1 + int'(rand_bits(5));
        s5 = int'(rand_bits(6));
        n5 = 1 + int'(rand_bits(5));
        words += 2 * c4 + n4 + 2 * n5;
        limit_cycles = 2000 + 8 * words;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Whole input region gets known data
        fill_input(0, out_base);

        fill_input(s1, n1);
        check_region(s1, n1);
        finish_test("burst write and read back");

        w = rand_bits(32);
        m = int'(rand_bits(2));
        start_run(m, c2, w);
        check_reg("weight", reg_weight, w);
        check_reg("ctrl", reg_ctrl, ctrl_word(m, c2, 1'b0));
        check_reg("status", reg_status, 32'h2);
        wait_irq(c2);
        check_reg("status", reg_status, 32'h1);
        check_region(out_base, c2);
        finish_test("registers and status");

        for (m = 0; m < 4; m++) begin
            start_run(m, cm[m], rand_bits(32));
            wait_irq(cm[m]);
            check_region(out_base, cm[m]);
            finish_test($sformatf("engine mode %0d", m));
        end

        // Host reads compete with the running engine
        m = int'(rand_bits(2));
        start_run(m, c4, rand_bits(32));
        check_region(s4, n4);
        wait_irq(c4);
        check_region(out_base, c4);
        finish_test("host reads during a run");

        gap_lvl = 3;
        fill_input(s5, n5);
        check_region(s5, n5);
        chk0.check_value("int_o", 32'(irq), 32'h1);
        write_word(reg_ctrl, ctrl_word(0, 0, 1'b0));
        chk0.check_value("int_o", 32'(irq), 32'h0);
        check_reg("status", reg_status, 32'h0);
        finish_test("back-pressure and interrupt clear");
        gap_lvl = 1;

        chk0.report();
        if (chk0.error_count() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized from the drawn test lengths
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not complete", limit_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/epu_bus_pkg.sv
rtl/epu_core_pkg.sv
rtl/sram_if.sv
rtl/epu_slave_port.sv
rtl/buffer_arbiter.sv
rtl/buffer_sram.sv
rtl/conv_engine.sv
rtl/epu_top.sv
verif/epu_checker.sv
verif/epu_assertions.sv
verif/epu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module epu_tb -f compile.f -o epu_sim

out=$(./obj_dir/epu_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Everything OK'; then
    exit 0
fi
exit 1
